//--- src/mmuPkg.sv
`default_nettype none

package mmuPkg;

    localparam int paLen = 32;
    localparam int pageOffsetBits = 12;

    typedef logic [18:0] vppnT;     // va[31:13]
    typedef logic [19:0] ppnT;
    typedef logic [9:0] asidT;
    typedef logic [1:0] plvT;
    typedef logic [1:0] matT;

    // one 4 KiB half of a page pair
    typedef struct packed {
        ppnT ppn;
        plvT plv;
        matT mat;
        logic dirty;
        logic valid;
    } tlbPageT;

    typedef struct packed {
        vppnT vppn;
        asidT asid;
        logic isGlobal;
        tlbPageT page0;             // even page
        tlbPageT page1;             // odd page
    } tlbEntryT;

    typedef struct packed {
        matT datm;
        matT datf;
        logic pg;
        logic da;
        logic ie;
        plvT plv;
    } crmdT;

    typedef struct packed {
        logic [2:0] vseg;
        logic rsvd28;
        logic [2:0] pseg;
        logic [18:0] rsvd24to6;
        matT mat;
        logic plv3;
        logic [1:0] rsvd2to1;
        logic plv0;
    } dmwT;

endpackage

`default_nettype wire

//--- src/excPkg.sv
`default_nettype none

package excPkg;

    typedef enum logic [1:0] {
        accFetch = 2'd0,
        accLoad  = 2'd1,
        accStore = 2'd2
    } accessT;

    // subtype numbers of the mmu instruction class
    typedef enum logic [4:0] {
        opSrch = 5'd1,
        opWr   = 5'd3
    } tlbOpT;

    typedef enum logic [5:0] {
        excPil  = 6'h01,
        excPis  = 6'h02,
        excPif  = 6'h03,
        excPme  = 6'h04,
        excPpi  = 6'h07,
        excAde  = 6'h08,
        excTlbr = 6'h3f
    } excCodeT;

    typedef logic [8:0] excSubT;

    localparam excSubT subDefault = 9'd0;
    localparam excSubT subAdef    = 9'd0;
    localparam excSubT subAdem    = 9'd1;

    typedef struct packed {
        logic valid;
        excSubT sub;
        excCodeT code;
    } excArgT;

endpackage

`default_nettype wire

//--- src/tlbEntryIf.sv
`timescale 1ns/10ps
`default_nettype none

interface tlbEntryIf #(
    parameter int tlbIndexWidth = 4
);
    localparam int tlbEntries = 1 << tlbIndexWidth;

    logic [tlbEntries-1:0] exist;
    logic [tlbEntries-1:0] isGlobal;
    mmuPkg::asidT asid [tlbEntries];
    mmuPkg::vppnT vppn [tlbEntries];
    mmuPkg::tlbPageT page0 [tlbEntries];
    mmuPkg::tlbPageT page1 [tlbEntries];

    modport store (output exist, isGlobal, asid, vppn, page0, page1);
    modport lookup (input exist, isGlobal, asid, vppn, page0, page1);

endinterface

`default_nettype wire

//--- src/tlbEntryStore.sv
`timescale 1ns/10ps
`default_nettype none

module tlbEntryStore #(
    parameter int tlbIndexWidth = 4
) (
    input logic clk,
    input logic rst,
    input logic wrEn,
    input logic [tlbIndexWidth-1:0] wrIndex,
    input logic wrExist,
    input mmuPkg::tlbEntryT wrEntry,
    tlbEntryIf.store entries
);

    // empty tlb out of reset
    always_ff @(posedge clk)
    begin
        if (rst)
            entries.exist <= '0;
        else if (wrEn)
            entries.exist[wrIndex] <= wrExist;   // NE inverted upstream
    end

    always_ff @(posedge clk)
    begin
        if (wrEn)
        begin
            entries.isGlobal[wrIndex] <= wrEntry.isGlobal;
            entries.asid[wrIndex] <= wrEntry.asid;
            entries.vppn[wrIndex] <= wrEntry.vppn;
            entries.page0[wrIndex] <= wrEntry.page0;
            entries.page1[wrIndex] <= wrEntry.page1;
        end
    end

    // index comes from tlbOpCtrl, must be clean on a write
    wrIndexKnown: assert property (
        @(posedge clk) disable iff (rst)
        wrEn |-> !$isunknown(wrIndex)
    );

endmodule

`default_nettype wire

//--- src/tlbMatch.sv
`timescale 1ns/10ps
`default_nettype none

module tlbMatch #(
    parameter int tlbIndexWidth = 4
) (
    tlbEntryIf.lookup entries,
    input mmuPkg::asidT asid,
    input mmuPkg::vppnT vppn,
    output logic hit,
    output logic [tlbIndexWidth-1:0] hitIndex
);

    localparam int tlbEntries = 1 << tlbIndexWidth;

    logic [tlbEntries-1:0] match;

    always_comb
    begin
        for (int i = 0; i < tlbEntries; i++)
        begin
            match[i] = entries.exist[i]
                && (entries.isGlobal[i] || entries.asid[i] == asid)
                && entries.vppn[i] == vppn;
        end
    end

    assign hit = |match;

    // binary tree, upper half wins at each level
    always_comb
    begin
        logic [tlbEntries-1:0] window;
        logic [tlbEntries-1:0] lowMask;
        logic [tlbEntries-1:0] upper;
        window = match;
        for (int lvl = tlbIndexWidth - 1; lvl >= 0; lvl--)
        begin
            lowMask = {tlbEntries{1'b1}} >> (tlbEntries - (1 << lvl));
            upper = (window >> (1 << lvl)) & lowMask;
            hitIndex[lvl] = |upper;
            window = hitIndex[lvl] ? upper : (window & lowMask);
        end
    end

    // duplicate keys written by software would alias here
    always_comb
    begin
        if (!$isunknown(match))
            matchOneHot: assert ($onehot0(match));
    end

endmodule

`default_nettype wire

//--- src/tlbOpCtrl.sv
`timescale 1ns/10ps
`default_nettype none

module tlbOpCtrl #(
    parameter int tlbIndexWidth = 4
) (
    input logic clk,
    input logic rst,
    input logic tlbOpValid,
    input excPkg::tlbOpT tlbOpKind,
    input logic [31:0] tlbIdx,
    input logic [31:0] tlbEhi,
    input logic [31:0] tlbElo0,
    input logic [31:0] tlbElo1,
    input mmuPkg::asidT asid,
    input logic srchHit,
    input logic [tlbIndexWidth-1:0] srchIndex,
    output logic wrEn,
    output logic [tlbIndexWidth-1:0] wrIndex,
    output logic wrExist,
    output mmuPkg::tlbEntryT wrEntry,
    output logic [31:0] tlbIdxOut
);

    logic srchEn;
    logic [31:0] idxNext;

    // elo: v, d, plv, mat, g, then ppn from bit 8
    function automatic mmuPkg::tlbPageT eloToPage(input logic [31:0] elo);
        mmuPkg::tlbPageT page;
        page.ppn = elo[mmuPkg::paLen-5:8];
        page.mat = elo[5:4];
        page.plv = elo[3:2];
        page.dirty = elo[1];
        page.valid = elo[0];
        return page;
    endfunction

    assign srchEn = tlbOpValid && tlbOpKind == excPkg::opSrch;
    assign wrEn = tlbOpValid && tlbOpKind == excPkg::opWr;

    assign wrIndex = tlbIdx[tlbIndexWidth-1:0];
    assign wrExist = ~tlbIdx[31];
    assign wrEntry.vppn = tlbEhi[31:13];
    assign wrEntry.asid = asid;
    assign wrEntry.isGlobal = tlbElo0[6] & tlbElo1[6];    // both halves must agree
    assign wrEntry.page0 = eloToPage(tlbElo0);
    assign wrEntry.page1 = eloToPage(tlbElo1);

    always_comb
    begin
        idxNext = tlbIdx;
        idxNext[31] = ~srchHit;         // NE
        if (srchHit)
            idxNext[tlbIndexWidth-1:0] = srchIndex;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            tlbIdxOut <= '0;
        else if (srchEn)
            tlbIdxOut <= idxNext;
    end

    opKindKnown: assert property (
        @(posedge clk) disable iff (rst)
        tlbOpValid |-> tlbOpKind inside {excPkg::opSrch, excPkg::opWr}
    );

endmodule

`default_nettype wire

//--- src/addrTranslate.sv
`timescale 1ns/10ps
`default_nettype none

module addrTranslate #(
    parameter int tlbIndexWidth = 4
) (
    input logic clk,
    input logic rst,
    input logic stall,
    input logic flush,
    input logic vaValid,
    input logic [31:0] va,
    input excPkg::accessT access,
    input mmuPkg::crmdT crmd,
    input mmuPkg::dmwT dmw0,
    input mmuPkg::dmwT dmw1,
    tlbEntryIf.lookup entries,
    input logic hit,
    input logic [tlbIndexWidth-1:0] hitIndex,
    output logic paValid,
    output logic [mmuPkg::paLen-1:0] pa,
    output mmuPkg::matT memType,
    output excPkg::excArgT excArg
);

    mmuPkg::tlbPageT page;
    logic [mmuPkg::paLen-1:0] paNext;
    mmuPkg::matT memTypeNext;
    excPkg::excArgT excNext;
    logic excRaised;

    function automatic logic windowHit(input mmuPkg::dmwT dmw, input mmuPkg::plvT plv,
                                       input logic [2:0] seg);
        return ((dmw.plv0 && plv == 2'd0) || (dmw.plv3 && plv == 2'd3)) && dmw.vseg == seg;
    endfunction

    function automatic excPkg::excArgT makeExc(input logic valid, input excPkg::excSubT sub,
                                               input excPkg::excCodeT code);
        excPkg::excArgT arg;
        arg.valid = valid;
        arg.sub = sub;
        arg.code = code;
        return arg;
    endfunction

    // va bit 12 picks the odd page of the pair
    assign page = va[mmuPkg::pageOffsetBits] ? entries.page1[hitIndex]
                                             : entries.page0[hitIndex];

    always_comb
    begin
        paNext = {page.ppn, va[mmuPkg::pageOffsetBits-1:0]};
        memTypeNext = page.mat;
        excNext = '0;
        excRaised = 1'b1;
        if (crmd.da && !crmd.pg)
        begin
            paNext = va;
            memTypeNext = (access == excPkg::accFetch) ? crmd.datf : crmd.datm;
            excRaised = 1'b0;
        end
        else if (windowHit(dmw0, crmd.plv, va[31:29]))
        begin
            paNext = {dmw0.pseg, va[28:0]};
            memTypeNext = dmw0.mat;
            excRaised = 1'b0;
        end
        else if (windowHit(dmw1, crmd.plv, va[31:29]))
        begin
            paNext = {dmw1.pseg, va[28:0]};
            memTypeNext = dmw1.mat;
            excRaised = 1'b0;
        end
        else if (crmd.plv != 2'd0 && va[31])
        begin
            if (access == excPkg::accFetch)
                excNext = makeExc(vaValid, excPkg::subAdef, excPkg::excAde);
            else
                excNext = makeExc(vaValid, excPkg::subAdem, excPkg::excAde);
        end
        else if (!hit)
            excNext = makeExc(vaValid, excPkg::subDefault, excPkg::excTlbr);
        else if (!page.valid)
        begin
            case (access)
                excPkg::accFetch: excNext = makeExc(vaValid, excPkg::subDefault, excPkg::excPif);
                excPkg::accStore: excNext = makeExc(vaValid, excPkg::subDefault, excPkg::excPis);
                default:          excNext = makeExc(vaValid, excPkg::subDefault, excPkg::excPil);
            endcase
        end
        else if (crmd.plv > page.plv)
            excNext = makeExc(vaValid, excPkg::subDefault, excPkg::excPpi);
        else if (access == excPkg::accStore && !page.dirty)
            excNext = makeExc(vaValid, excPkg::subDefault, excPkg::excPme);
        else
            excRaised = 1'b0;           // clean tlb hit
    end

    // flush beats stall
    always_ff @(posedge clk)
    begin
        if (rst || flush)
        begin
            paValid <= 1'b0;
            pa <= '0;
            memType <= '0;
            excArg <= '0;
        end
        else if (!stall)
        begin
            paValid <= vaValid && !excRaised;
            pa <= paNext;
            memType <= memTypeNext;
            excArg <= excNext;
        end
    end

    paExcExclusive: assert property (
        @(posedge clk) disable iff (rst)
        !(paValid && excArg.valid)
    );

endmodule

`default_nettype wire

//--- src/mmuTop.sv
`timescale 1ns/10ps
`default_nettype none

module mmuTop #(
    parameter int tlbIndexWidth = 4
) (
    input logic clk,
    input logic rst,
    input mmuPkg::crmdT crmd,
    input mmuPkg::asidT asid,
    input mmuPkg::dmwT dmw0,
    input mmuPkg::dmwT dmw1,
    input logic tlbOpValid,
    input excPkg::tlbOpT tlbOpKind,
    input logic [31:0] tlbIdx,
    input logic [31:0] tlbEhi,
    input logic [31:0] tlbElo0,
    input logic [31:0] tlbElo1,
    output logic [31:0] tlbIdxOut,
    input logic stall,
    input logic flush,
    input logic vaValid,
    input logic [31:0] va,
    input excPkg::accessT access,
    output logic paValid,
    output logic [31:0] pa,
    output mmuPkg::matT memType,
    output excPkg::excArgT excArg
);

    logic wrEn;
    logic [tlbIndexWidth-1:0] wrIndex;
    logic wrExist;
    mmuPkg::tlbEntryT wrEntry;
    logic srchHit;
    logic [tlbIndexWidth-1:0] srchIndex;
    logic xlatHit;
    logic [tlbIndexWidth-1:0] xlatIndex;

    tlbEntryIf #(.tlbIndexWidth(tlbIndexWidth)) entries ();

    tlbEntryStore #(.tlbIndexWidth(tlbIndexWidth)) store0 (
        .clk(clk),
        .rst(rst),
        .wrEn(wrEn),
        .wrIndex(wrIndex),
        .wrExist(wrExist),
        .wrEntry(wrEntry),
        .entries(entries.store)
    );

    // key for TLBSRCH
    tlbMatch #(.tlbIndexWidth(tlbIndexWidth)) srchMatch (
        .entries(entries.lookup),
        .asid(asid),
        .vppn(tlbEhi[31:13]),
        .hit(srchHit),
        .hitIndex(srchIndex)
    );

    tlbMatch #(.tlbIndexWidth(tlbIndexWidth)) xlatMatch (
        .entries(entries.lookup),
        .asid(asid),
        .vppn(va[31:13]),
        .hit(xlatHit),
        .hitIndex(xlatIndex)
    );

    tlbOpCtrl #(.tlbIndexWidth(tlbIndexWidth)) opCtrl0 (
        .clk(clk),
        .rst(rst),
        .tlbOpValid(tlbOpValid),
        .tlbOpKind(tlbOpKind),
        .tlbIdx(tlbIdx),
        .tlbEhi(tlbEhi),
        .tlbElo0(tlbElo0),
        .tlbElo1(tlbElo1),
        .asid(asid),
        .srchHit(srchHit),
        .srchIndex(srchIndex),
        .wrEn(wrEn),
        .wrIndex(wrIndex),
        .wrExist(wrExist),
        .wrEntry(wrEntry),
        .tlbIdxOut(tlbIdxOut)
    );

    addrTranslate #(.tlbIndexWidth(tlbIndexWidth)) xlat0 (
        .clk(clk),
        .rst(rst),
        .stall(stall),
        .flush(flush),
        .vaValid(vaValid),
        .va(va),
        .access(access),
        .crmd(crmd),
        .dmw0(dmw0),
        .dmw1(dmw1),
        .entries(entries.lookup),
        .hit(xlatHit),
        .hitIndex(xlatIndex),
        .paValid(paValid),
        .pa(pa),
        .memType(memType),
        .excArg(excArg)
    );

endmodule

`default_nettype wire

//--- test/tbMmu.sv
`timescale 1ns/10ps
`default_nettype none

module tbMmu;

    localparam int tlbIndexWidth = 4;
    localparam int tlbEntries = 1 << tlbIndexWidth;
    localparam int resetCycles = 3;
    localparam int cyclesPerStep = 40;
    localparam int testSteps = 120;     // all test steps with headroom

    logic clk;
    logic rst;
    mmuPkg::crmdT crmd;
    mmuPkg::asidT asid;
    mmuPkg::dmwT dmw0;
    mmuPkg::dmwT dmw1;
    logic tlbOpValid;
    excPkg::tlbOpT tlbOpKind;
    logic [31:0] tlbIdx;
    logic [31:0] tlbEhi;
    logic [31:0] tlbElo0;
    logic [31:0] tlbElo1;
    logic [31:0] tlbIdxOut;
    logic stall;
    logic flush;
    logic vaValid;
    logic [31:0] va;
    excPkg::accessT access;
    logic paValid;
    logic [31:0] pa;
    mmuPkg::matT memType;
    excPkg::excArgT excArg;

    integer seed = 32'h59ea_6bcf;
    logic failed = 1'b0;

    // mirror of every TLBWR
    logic modelExist [tlbEntries];
    mmuPkg::tlbEntryT modelEntry [tlbEntries];

    mmuTop #(.tlbIndexWidth(tlbIndexWidth)) dut0 (
        .clk(clk),
        .rst(rst),
        .crmd(crmd),
        .asid(asid),
        .dmw0(dmw0),
        .dmw1(dmw1),
        .tlbOpValid(tlbOpValid),
        .tlbOpKind(tlbOpKind),
        .tlbIdx(tlbIdx),
        .tlbEhi(tlbEhi),
        .tlbElo0(tlbElo0),
        .tlbElo1(tlbElo1),
        .tlbIdxOut(tlbIdxOut),
        .stall(stall),
        .flush(flush),
        .vaValid(vaValid),
        .va(va),
        .access(access),
        .paValid(paValid),
        .pa(pa),
        .memType(memType),
        .excArg(excArg)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic failNow();
        failed = 1'b1;
        $display("Finished with errors");
        $fatal(1, "run stopped at the first failure");
    endtask

    initial
    begin
        repeat (resetCycles + cyclesPerStep * testSteps) @(posedge clk);
        $display("timeout: the tests did not complete within the cycle budget");
        failNow();
    end

    function automatic logic [31:0] randWord();
        return $random(seed);
    endfunction

    task automatic checkPaValid(input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("ERROR paValid: got 0x%h, expected 0x%h", got, exp);
            failNow();
        end
    endtask

    task automatic checkPa(input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("ERROR pa: got 0x%h, expected 0x%h", got, exp);
            failNow();
        end
    endtask

    task automatic checkExc(input excPkg::excArgT got, input excPkg::excArgT exp);
        if (got !== exp)
        begin
            $display("ERROR excArg: got 0x%h, expected 0x%h", got, exp);
            failNow();
        end
    endtask

    task automatic checkMemType(input mmuPkg::matT got, input mmuPkg::matT exp);
        if (got !== exp)
        begin
            $display("ERROR memType: got 0x%h, expected 0x%h", got, exp);
            failNow();
        end
    endtask

    task automatic checkIdx(input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("ERROR tlbIdxOut: got 0x%h, expected 0x%h", got, exp);
            failNow();
        end
    endtask

    function automatic mmuPkg::crmdT makeCrmd(input mmuPkg::plvT plv, input logic da,
                                              input logic pg, input mmuPkg::matT datf,
                                              input mmuPkg::matT datm);
        mmuPkg::crmdT c;
        c = '0;
        c.plv = plv;
        c.da = da;
        c.pg = pg;
        c.datf = datf;
        c.datm = datm;
        return c;
    endfunction

    function automatic mmuPkg::dmwT makeDmw(input logic en0, input logic en3,
                                            input mmuPkg::matT mat, input logic [2:0] pseg,
                                            input logic [2:0] vseg);
        mmuPkg::dmwT w;
        w = '0;
        w.plv0 = en0;
        w.plv3 = en3;
        w.mat = mat;
        w.pseg = pseg;
        w.vseg = vseg;
        return w;
    endfunction

    function automatic mmuPkg::tlbPageT makePage(input mmuPkg::ppnT ppn, input mmuPkg::plvT plv,
                                                 input mmuPkg::matT mat, input logic dirty,
                                                 input logic valid);
        mmuPkg::tlbPageT p;
        p.ppn = ppn;
        p.plv = plv;
        p.mat = mat;
        p.dirty = dirty;
        p.valid = valid;
        return p;
    endfunction

    // elo image with ppn at 27..8 and g at 6
    function automatic logic [31:0] pageToElo(input mmuPkg::tlbPageT p, input logic g);
        return {4'h0, p.ppn, 1'b0, g, p.mat, p.plv, p.dirty, p.valid};
    endfunction

    function automatic logic vppnInUse(input mmuPkg::vppnT v);
        logic used;
        used = 1'b0;
        for (int i = 0; i < tlbEntries; i++)
        begin
            if (modelExist[i] && modelEntry[i].vppn == v)
                used = 1'b1;
        end
        return used;
    endfunction

    // va bit 31 kept low so plv3 can reach the tlb
    function automatic mmuPkg::vppnT freshVppn();
        logic [31:0] w;
        w = randWord();
        w[18] = 1'b0;
        while (vppnInUse(w[18:0]))
        begin
            w = randWord();
            w[18] = 1'b0;
        end
        return w[18:0];
    endfunction

    function automatic int freeIndex();
        logic [31:0] w;
        w = randWord();
        while (modelExist[w[tlbIndexWidth-1:0]])
            w = randWord();
        return int'(w[tlbIndexWidth-1:0]);
    endfunction

    function automatic mmuPkg::tlbEntryT newEntry(input mmuPkg::asidT id, input logic glob);
        mmuPkg::tlbEntryT e;
        logic [31:0] r0;
        logic [31:0] r1;
        r0 = randWord();
        r1 = randWord();
        e.vppn = freshVppn();
        e.asid = id;
        e.isGlobal = glob;
        e.page0 = makePage(r0[19:0], 2'd3, r0[21:20], 1'b1, 1'b1);
        e.page1 = makePage(r1[19:0], 2'd3, r1[21:20], 1'b1, 1'b1);
        return e;
    endfunction

    function automatic logic lookupModel(input mmuPkg::vppnT key, input mmuPkg::asidT id,
                                         output int idx);
        logic found;
        found = 1'b0;
        idx = 0;
        for (int i = 0; i < tlbEntries; i++)
        begin
            if (modelExist[i] && modelEntry[i].vppn == key
                && (modelEntry[i].isGlobal || modelEntry[i].asid == id))
            begin
                found = 1'b1;
                idx = i;
            end
        end
        return found;
    endfunction

    function automatic logic windowCovers(input mmuPkg::dmwT w, input logic [31:0] addr);
        logic en;
        case (crmd.plv)
            2'd0: en = w.plv0;
            2'd3: en = w.plv3;
            default: en = 1'b0;
        endcase
        return en && w.vseg == addr[31:29];
    endfunction

    // expected result from the mode, the windows and the model table
    task automatic predict(input logic valid, input logic [31:0] addr, input excPkg::accessT kind,
                           output logic raised, output logic [31:0] expPa,
                           output mmuPkg::matT expMat, output excPkg::excArgT expExc);
        int idx;
        mmuPkg::tlbPageT pg;
        raised = 1'b1;
        expPa = '0;
        expMat = '0;
        expExc = '0;
        if (crmd.da && !crmd.pg)
        begin
            raised = 1'b0;
            expPa = addr;
            expMat = (kind == excPkg::accFetch) ? crmd.datf : crmd.datm;
        end
        else if (windowCovers(dmw0, addr))
        begin
            raised = 1'b0;
            expPa = {dmw0.pseg, addr[28:0]};
            expMat = dmw0.mat;
        end
        else if (windowCovers(dmw1, addr))
        begin
            raised = 1'b0;
            expPa = {dmw1.pseg, addr[28:0]};
            expMat = dmw1.mat;
        end
        else if (crmd.plv != 2'd0 && addr[31])
        begin
            expExc.code = excPkg::excAde;
            expExc.sub = (kind == excPkg::accFetch) ? excPkg::subAdef : excPkg::subAdem;
        end
        else if (!lookupModel(addr[31:13], asid, idx))
            expExc.code = excPkg::excTlbr;
        else
        begin
            pg = addr[12] ? modelEntry[idx].page1 : modelEntry[idx].page0;
            expPa = {pg.ppn, addr[11:0]};
            expMat = pg.mat;
            if (!pg.valid)
                expExc.code = (kind == excPkg::accFetch) ? excPkg::excPif
                            : (kind == excPkg::accStore) ? excPkg::excPis : excPkg::excPil;
            else if (crmd.plv > pg.plv)
                expExc.code = excPkg::excPpi;
            else if (kind == excPkg::accStore && !pg.dirty)
                expExc.code = excPkg::excPme;
            else
                raised = 1'b0;
        end
        if (raised)
            expExc.valid = valid;
    endtask

    task automatic checkResult(input logic valid, input logic [31:0] addr,
                               input excPkg::accessT kind);
        logic raised;
        logic [31:0] expPa;
        mmuPkg::matT expMat;
        excPkg::excArgT expExc;
        predict(valid, addr, kind, raised, expPa, expMat, expExc);
        checkExc(excArg, expExc);
        checkPaValid(paValid, valid && !raised);
        if (!raised)
        begin
            checkPa(pa, expPa);
            checkMemType(memType, expMat);
        end
    endtask

    task automatic translate(input logic valid, input logic [31:0] addr,
                             input excPkg::accessT kind);
        @(posedge clk);
        vaValid <= valid;
        va <= addr;
        access <= kind;
        @(posedge clk);         // sampled here
        @(negedge clk);
        checkResult(valid, addr, kind);
    endtask

    task automatic setMode(input mmuPkg::crmdT c, input mmuPkg::dmwT d0, input mmuPkg::dmwT d1);
        @(posedge clk);
        crmd <= c;
        dmw0 <= d0;
        dmw1 <= d1;
    endtask

    task automatic setAsid(input mmuPkg::asidT id);
        @(posedge clk);
        asid <= id;
    endtask

    task automatic writeEntry(input int idx, input mmuPkg::tlbEntryT e);
        @(posedge clk);
        tlbOpValid <= 1'b1;
        tlbOpKind <= excPkg::opWr;
        tlbIdx <= 32'(idx);     // NE clear
        tlbEhi <= {e.vppn, 13'h0};
        tlbElo0 <= pageToElo(e.page0, e.isGlobal);
        tlbElo1 <= pageToElo(e.page1, e.isGlobal);
        asid <= e.asid;
        @(posedge clk);
        tlbOpValid <= 1'b0;
        modelExist[idx] = 1'b1;
        modelEntry[idx] = e;
    endtask

    task automatic searchKey(input mmuPkg::vppnT key, input mmuPkg::asidT id);
        logic [31:0] image;
        logic [31:0] noise;
        logic [31:0] expIdx;
        int idx;
        image = randWord();
        noise = randWord();
        @(posedge clk);
        tlbOpValid <= 1'b1;
        tlbOpKind <= excPkg::opSrch;
        tlbEhi <= {key, noise[12:0]};
        tlbIdx <= image;
        asid <= id;
        @(posedge clk);
        tlbOpValid <= 1'b0;
        @(negedge clk);
        expIdx = image;
        if (lookupModel(key, id, idx))
        begin
            expIdx[31] = 1'b0;
            expIdx[tlbIndexWidth-1:0] = idx[tlbIndexWidth-1:0];
        end
        else
            expIdx[31] = 1'b1;
        checkIdx(tlbIdxOut, expIdx);
    endtask

    task automatic testReset();
        @(negedge clk);
        checkPaValid(paValid, 1'b0);
        checkExc(excArg, '0);
        checkIdx(tlbIdxOut, 32'h0);
        setMode(makeCrmd(2'd0, 1'b0, 1'b1, 2'd0, 2'd0), '0, '0);
        translate(1'b1, randWord(), excPkg::accLoad);  // empty tlb
    endtask

    task automatic testDirectWindows();
        mmuPkg::dmwT w0;
        mmuPkg::dmwT w1;
        logic [31:0] r;
        setMode(makeCrmd(2'd0, 1'b1, 1'b0, 2'd1, 2'd2), '0, '0);
        translate(1'b1, randWord(), excPkg::accFetch);
        translate(1'b1, randWord(), excPkg::accLoad);
        translate(1'b1, randWord(), excPkg::accStore);
        w0 = makeDmw(1'b1, 1'b0, 2'd1, 3'b001, 3'b101);
        w1 = makeDmw(1'b0, 1'b1, 2'd2, 3'b010, 3'b100);
        r = randWord();
        setMode(makeCrmd(2'd0, 1'b0, 1'b1, 2'd0, 2'd0), w0, w1);
        translate(1'b1, {3'b101, r[28:0]}, excPkg::accLoad);
        translate(1'b1, {3'b100, r[28:0]}, excPkg::accFetch);   // w1 off at plv0
        setMode(makeCrmd(2'd3, 1'b0, 1'b1, 2'd0, 2'd0), w0, w1);
        translate(1'b1, {3'b100, r[28:0]}, excPkg::accStore);
        translate(1'b1, {3'b101, r[28:0]}, excPkg::accLoad);    // w0 off at plv3
    endtask

    task automatic testTlbOps();
        mmuPkg::tlbEntryT e;
        int idx;
        for (int n = 0; n < 8; n++)
        begin
            idx = freeIndex();
            e = newEntry(mmuPkg::asidT'(randWord()), n % 3 == 0);
            writeEntry(idx, e);
            searchKey(e.vppn, e.asid);
        end
        searchKey(freshVppn(), mmuPkg::asidT'(randWord()));
        // only global entries hit under another asid
        for (int i = 0; i < tlbEntries; i++)
        begin
            if (modelExist[i])
                searchKey(modelEntry[i].vppn, modelEntry[i].asid ^ 10'h2a5);
        end
    endtask

    task automatic testTlbXlat();
        logic [31:0] r;
        setMode(makeCrmd(2'd0, 1'b0, 1'b1, 2'd0, 2'd0), '0, '0);
        for (int i = 0; i < tlbEntries; i++)
        begin
            if (modelExist[i])
            begin
                r = randWord();
                if (modelEntry[i].isGlobal)
                    setAsid(modelEntry[i].asid ^ 10'h155);
                else
                    setAsid(modelEntry[i].asid);
                translate(1'b1, {modelEntry[i].vppn, 1'b0, r[11:0]}, excPkg::accLoad);
                translate(1'b1, {modelEntry[i].vppn, 1'b1, r[11:0]}, excPkg::accStore);
            end
        end
    endtask

    task automatic testExceptions();
        mmuPkg::tlbEntryT e;
        logic [31:0] r;
        setMode(makeCrmd(2'd3, 1'b0, 1'b1, 2'd0, 2'd0), '0, '0);
        r = randWord();
        translate(1'b1, {1'b1, r[30:0]}, excPkg::accFetch);
        translate(1'b1, {1'b1, r[30:0]}, excPkg::accStore);
        translate(1'b0, {1'b1, r[30:0]}, excPkg::accLoad);
        // invalid even page and clean plv0 odd page
        e = newEntry(mmuPkg::asidT'(randWord()), 1'b0);
        e.page0.valid = 1'b0;
        e.page1.plv = 2'd0;
        e.page1.dirty = 1'b0;
        writeEntry(freeIndex(), e);
        setMode(makeCrmd(2'd0, 1'b0, 1'b1, 2'd0, 2'd0), '0, '0);
        translate(1'b1, {e.vppn, 1'b0, r[11:0]}, excPkg::accFetch);
        translate(1'b1, {e.vppn, 1'b0, r[11:0]}, excPkg::accLoad);
        translate(1'b1, {e.vppn, 1'b0, r[11:0]}, excPkg::accStore);
        translate(1'b0, {e.vppn, 1'b0, r[11:0]}, excPkg::accLoad);
        translate(1'b1, {e.vppn, 1'b1, r[11:0]}, excPkg::accStore);
        translate(1'b1, {e.vppn, 1'b1, r[11:0]}, excPkg::accLoad);
        setMode(makeCrmd(2'd3, 1'b0, 1'b1, 2'd0, 2'd0), '0, '0);
        translate(1'b1, {e.vppn, 1'b1, r[11:0]}, excPkg::accLoad);
        translate(1'b0, {e.vppn, 1'b1, r[11:0]}, excPkg::accFetch);
    endtask

    task automatic testStallFlush();
        logic [31:0] a;
        logic [31:0] b;
        a = randWord();
        b = randWord();
        setMode(makeCrmd(2'd0, 1'b1, 1'b0, 2'd3, 2'd1), '0, '0);
        translate(1'b1, a, excPkg::accLoad);
        @(posedge clk);
        stall <= 1'b1;
        va <= b;
        access <= excPkg::accFetch;
        repeat (2) @(posedge clk);
        @(negedge clk);
        checkResult(1'b1, a, excPkg::accLoad);     // held
        @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        @(negedge clk);
        checkPaValid(paValid, 1'b0);
        checkPa(pa, 32'h0);
        checkMemType(memType, 2'd0);
        checkExc(excArg, '0);
        @(posedge clk);
        stall <= 1'b0;
        translate(1'b1, b, excPkg::accFetch);
    endtask

    initial
    begin
        rst <= 1'b1;
        crmd <= '0;
        asid <= '0;
        dmw0 <= '0;
        dmw1 <= '0;
        tlbOpValid <= 1'b1;     // search and translation busy under reset
        tlbOpKind <= excPkg::opSrch;
        tlbIdx <= '0;
        tlbEhi <= '0;
        tlbElo0 <= '0;
        tlbElo1 <= '0;
        stall <= 1'b0;
        flush <= 1'b0;
        vaValid <= 1'b1;
        va <= '0;
        access <= excPkg::accLoad;
        for (int i = 0; i < tlbEntries; i++)
            modelExist[i] = 1'b0;
        repeat (resetCycles) @(posedge clk);
        rst <= 1'b0;
        tlbOpValid <= 1'b0;
        vaValid <= 1'b0;
        testReset();
        testDirectWindows();
        testTlbOps();
        testTlbXlat();
        testExceptions();
        testStallFlush();
        if (!failed)
        begin
            $display("Finished with no errors");
            $finish;
        end
        else
            failNow();
    end

endmodule

`default_nettype wire

//--- verilog.f
src/mmuPkg.sv
src/excPkg.sv
src/tlbEntryIf.sv
src/tlbEntryStore.sv
src/tlbMatch.sv
src/tlbOpCtrl.sv
src/addrTranslate.sv
src/mmuTop.sv
test/tbMmu.sv

//--- Makefile
LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tbMmu -f verilog.f -o tbMmu
	./obj_dir/tbMmu | tee $(LOG)
	grep -q "Finished with no errors" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
